/* include/lac_defines.svh */
/*
  sizes of the reduced LAC sparse multiplier
  LAC_H must be a multiple of LAC_LANES, and LAC_Q must stay below 2^LAC_COEFF_W
*/

`ifndef LAC_DEFINES_SVH
`define LAC_DEFINES_SVH

// ------------------------------
// ring parameters
// ------------------------------

// coefficient modulus
`define LAC_Q 251

// polynomial length, ring is mod x^N+1
`define LAC_N 64

// nonzero entries of the sparse operand, first half +1, rest -1
`define LAC_H 16

// ------------------------------
// datapath shape
// ------------------------------

// positions consumed per pass
`define LAC_LANES 4

// bits per stored coefficient
`define LAC_COEFF_W 8

`endif

/* design/lac_pkg.sv */
/*
  shared types of the sparse multiplier
  widths follow lac_defines.svh, positions are indices into the dense operand
*/

`include "lac_defines.svh"

package lac_pkg;

  // one coefficient, always kept below LAC_Q
  typedef logic [`LAC_COEFF_W-1:0] coeff_t;

  // index into the dense polynomial
  typedef logic [$clog2(`LAC_N)-1:0] pos_t;

  // one position memory word, lane 0 in the low bits
  typedef pos_t [`LAC_LANES-1:0] pos_word_t;

  // one coefficient per lane
  typedef coeff_t [`LAC_LANES-1:0] coeff_vec_t;

  // per lane negate request
  typedef logic [`LAC_LANES-1:0] flag_vec_t;

  // pass number, also the position memory address
  typedef logic [$clog2(`LAC_H / `LAC_LANES)-1:0] pass_t;

  // pass sequencing in operand_fetch
  typedef enum logic [1:0] {
    IDLE,
    LOAD_POS,
    STREAM,
    DRAIN
  } fetch_state_e;

endpackage

/* design/lac_stream_if.sv */
/*
  point to point streams between the three stages
  valid only, the consumers never stall
*/

`timescale 1ns/1ps

// one output index with the lane operands feeding it
interface term_if import lac_pkg::*; ();
  logic       valid;
  pos_t       k;
  coeff_vec_t coeffs;
  flag_vec_t  negate;
  logic       first_pass;

  modport src (output valid, k, coeffs, negate, first_pass);
  modport dst (input valid, k, coeffs, negate, first_pass);
endinterface

// reduced lane sum for one output index
interface acc_if import lac_pkg::*; ();
  logic   valid;
  pos_t   k;
  coeff_t sum;
  logic   first_pass;
  logic   last;

  modport src (output valid, k, sum, first_pass, last);
  modport dst (input valid, k, sum, first_pass, last);
endinterface

/* design/operand_fetch.sv */
/*
  loads and sequences the operands, LAC_LANES positions per pass
  positions must be distinct and below LAC_N, loads are dropped while busy
  the next pass waits for pass_done from the result stage
*/

`timescale 1ns/1ps

`include "lac_defines.svh"

module operand_fetch
  import lac_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start,
  output logic      busy,
  output logic      done,
  input  logic      poly_wr_en,
  input  pos_t      poly_wr_addr,
  input  coeff_t    poly_wr_data,
  input  logic      pos_wr_en,
  input  pass_t     pos_wr_addr,
  input  pos_word_t pos_wr_data,
  input  logic      pass_done,
  term_if.src       term
);

  localparam int PASSES = `LAC_H / `LAC_LANES;

  fetch_state_e state;
  pass_t        pass;
  pos_t         k_cnt;

  // storage, one dense copy per lane so all lanes read in parallel
  pos_word_t pos_mem [PASSES];
  coeff_t    dense_mem [`LAC_LANES][`LAC_N];
  pos_word_t pos_q;

  pos_t      rd_addr [`LAC_LANES];
  flag_vec_t neg_next;

  assign busy = (state != IDLE);

  // ------------------------------
  // pass sequencing
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= IDLE;
      pass  <= '0;
      k_cnt <= '0;
      done  <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      case (state)
        IDLE:
          if (start)
          begin
            pass  <= '0;
            state <= LOAD_POS;
          end
        LOAD_POS:
        begin
          k_cnt <= '0;
          state <= STREAM;
        end
        STREAM:
        begin
          // k_cnt wraps back to zero after the last index
          k_cnt <= k_cnt + 1'b1;
          if (k_cnt == pos_t'(`LAC_N - 1))
            state <= DRAIN;
        end
        DRAIN:
          if (pass_done)
          begin
            if (pass == pass_t'(PASSES - 1))
            begin
              state <= IDLE;
              done  <= 1'b1;
            end
            else
            begin
              pass  <= pass + 1'b1;
              state <= LOAD_POS;
            end
          end
        default:
          state <= IDLE;
      endcase
    end
  end

  // ------------------------------
  // memories and operand read
  // ------------------------------

  // lane l reads a[(k - p) mod N], i.e. starts at N - p and steps by one
  // negative wrap flips the sign, so does a position from the second half
  always_comb
  begin
    for (int l = 0; l < `LAC_LANES; l++)
    begin
      rd_addr[l]  = k_cnt - pos_q[l];
      neg_next[l] = (k_cnt < pos_q[l]) !=
                    ((int'(pass) * `LAC_LANES + l) >= (`LAC_H / 2));
    end
  end

  always_ff @(posedge clk)
  begin
    if (pos_wr_en && !busy)
      pos_mem[pos_wr_addr] <= pos_wr_data;
    if (state == LOAD_POS)
      pos_q <= pos_mem[pass];
    for (int l = 0; l < `LAC_LANES; l++)
    begin
      if (poly_wr_en && !busy)
        dense_mem[l][poly_wr_addr] <= poly_wr_data;
      term.coeffs[l] <= dense_mem[l][rd_addr[l]];
    end
    term.negate     <= neg_next;
    term.k          <= k_cnt;
    term.first_pass <= (pass == '0);
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      term.valid <= 1'b0;
    else
      term.valid <= (state == STREAM);
  end

  // operands may only change between runs
  a_no_load_busy: assert property (@(posedge clk) disable iff (!rst_n)
    busy |-> !(poly_wr_en || pos_wr_en))
    else $error("operand write while busy");

  // the result stage can only finish a pass that was fully issued
  a_done_in_drain: assert property (@(posedge clk) disable iff (!rst_n)
    pass_done |-> (state == DRAIN))
    else $error("pass_done outside DRAIN");

endmodule

/* design/term_accumulate.sv */
/*
  sign correction, lane sum and reduction mod LAC_Q, three register stages
  the single fold plus one subtract only covers sums up to 4*LAC_Q
*/

`timescale 1ns/1ps

`include "lac_defines.svh"

module term_accumulate
  import lac_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  term_if.dst  term,
  acc_if.src   acc
);

  localparam int SUM_W  = `LAC_COEFF_W + $clog2(`LAC_LANES);
  localparam int FOLD_W = `LAC_COEFF_W + 1;
  localparam int HI_W   = SUM_W - `LAC_COEFF_W;

  // stage 1
  coeff_t           corr [`LAC_LANES];
  logic [SUM_W-1:0] lane_sum;
  logic [SUM_W-1:0] s1_sum;
  pos_t             s1_k;
  logic             s1_valid;
  logic             s1_first;
  logic             s1_last;

  // stage 2
  logic [HI_W-1:0]   hi;
  logic [FOLD_W-1:0] fold;
  logic [FOLD_W-1:0] s2_fold;
  pos_t              s2_k;
  logic              s2_valid;
  logic              s2_first;
  logic              s2_last;

  // stage 3
  coeff_t reduced;

  // ------------------------------
  // combinational per stage
  // ------------------------------

  // -a is stored as Q - a, a zero coefficient turns into Q which is harmless
  always_comb
  begin
    lane_sum = '0;
    for (int l = 0; l < `LAC_LANES; l++)
    begin
      corr[l]  = term.negate[l] ? coeff_t'(`LAC_Q) - term.coeffs[l] : term.coeffs[l];
      lane_sum = lane_sum + SUM_W'(corr[l]);
    end
  end

  // 256 = 5 mod 251, so the bits above 8 come back in as 5 * hi
  assign hi   = s1_sum[SUM_W-1:`LAC_COEFF_W];
  assign fold = FOLD_W'(s1_sum[`LAC_COEFF_W-1:0]) + FOLD_W'({hi, 2'b00}) + FOLD_W'(hi);

  assign reduced = (s2_fold >= FOLD_W'(`LAC_Q)) ? coeff_t'(s2_fold - FOLD_W'(`LAC_Q))
                                                : coeff_t'(s2_fold);

  // ------------------------------
  // pipeline registers
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
      acc.valid <= 1'b0;
    end
    else
    begin
      s1_valid  <= term.valid;
      s2_valid  <= s1_valid;
      acc.valid <= s2_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    s1_sum         <= lane_sum;
    s1_k           <= term.k;
    s1_first       <= term.first_pass;
    s1_last        <= (term.k == pos_t'(`LAC_N - 1));
    s2_fold        <= fold;
    s2_k           <= s1_k;
    s2_first       <= s1_first;
    s2_last        <= s1_last;
    acc.sum        <= reduced;
    acc.k          <= s2_k;
    acc.first_pass <= s2_first;
    acc.last       <= s2_last;
  end

  a_sum_below_q: assert property (@(posedge clk) disable iff (!rst_n)
    acc.valid |-> (acc.sum < coeff_t'(`LAC_Q)))
    else $error("lane sum not reduced");

  // last is derived from k, so a burst of terms must count up without gaps
  a_k_in_order: assert property (@(posedge clk) disable iff (!rst_n)
    (term.valid && $past(term.valid)) |-> (term.k == pos_t'($past(term.k) + 1'b1)))
    else $error("term indices out of order");

endmodule

/* design/result_store.sv */
/*
  result memory with read-modify-write accumulation, write lands 2 cycles after acc
  external reads are dropped while a run is writing, data comes 1 cycle after res_rd_en
*/

`timescale 1ns/1ps

`include "lac_defines.svh"

module result_store
  import lac_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  acc_if.dst     acc,
  output logic   pass_done,
  input  logic   res_rd_en,
  input  pos_t   res_rd_addr,
  output coeff_t res_rd_data,
  output logic   res_rd_valid
);

  localparam int PASSES  = `LAC_H / `LAC_LANES;
  localparam int TOTAL_W = `LAC_COEFF_W + 1;

  coeff_t res_mem [`LAC_N];

  // read stage
  coeff_t a_stored;
  coeff_t a_sum;
  pos_t   a_k;
  logic   a_valid;
  logic   a_first;
  logic   a_last;

  // add stage
  logic [TOTAL_W-1:0] b_total;
  pos_t               b_k;
  logic               b_valid;
  logic               b_last;
  coeff_t             wr_data;

  // run tracking for the readback port
  pass_t pass_cnt;
  logic  running;
  logic  ext_rd;

  assign ext_rd  = res_rd_en && !running;
  assign wr_data = (b_total >= TOTAL_W'(`LAC_Q)) ? coeff_t'(b_total - TOTAL_W'(`LAC_Q))
                                                 : coeff_t'(b_total);

  // ------------------------------
  // accumulate path
  // ------------------------------
  always_ff @(posedge clk)
  begin
    a_stored <= res_mem[acc.k];
    a_sum    <= acc.sum;
    a_k      <= acc.k;
    a_first  <= acc.first_pass;
    a_last   <= acc.last;
    // old contents are garbage on the first pass, add zero instead
    b_total  <= TOTAL_W'(a_first ? coeff_t'(0) : a_stored) + TOTAL_W'(a_sum);
    b_k      <= a_k;
    b_last   <= a_last;
    if (b_valid)
      res_mem[b_k] <= wr_data;
    if (ext_rd)
      res_rd_data <= res_mem[res_rd_addr];
  end

  // ------------------------------
  // control
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      a_valid      <= 1'b0;
      b_valid      <= 1'b0;
      pass_done    <= 1'b0;
      pass_cnt     <= '0;
      running      <= 1'b0;
      res_rd_valid <= 1'b0;
    end
    else
    begin
      a_valid      <= acc.valid;
      b_valid      <= a_valid;
      pass_done    <= b_valid && b_last;
      res_rd_valid <= ext_rd;
      if (acc.valid && acc.first_pass)
        running <= 1'b1;
      if (pass_done)
      begin
        if (pass_cnt == pass_t'(PASSES - 1))
        begin
          pass_cnt <= '0;
          running  <= 1'b0;
        end
        else
          pass_cnt <= pass_cnt + 1'b1;
      end
    end
  end

  a_no_read_running: assert property (@(posedge clk) disable iff (!rst_n)
    running |-> !res_rd_en)
    else $error("result read while busy");

  // an index repeated while its earlier sum is still in flight would read a stale value
  a_no_rmw_hazard: assert property (@(posedge clk) disable iff (!rst_n)
    acc.valid |-> (!(a_valid && (a_k == acc.k)) && !(b_valid && (b_k == acc.k))))
    else $error("result index reused before its write landed");

endmodule

/* design/sparse_mul_top.sv */
/*
  sparse ternary times dense polynomial mod (x^N+1, Q), LAC style
  load both operands while idle, pulse start, read the result after done
  the first half of the positions carries +1, the second half -1
*/

`timescale 1ns/1ps

module sparse_mul_top
  import lac_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  // run control
  input  logic      start,
  output logic      busy,
  output logic      done,

  // dense operand load, one coefficient per address
  input  logic      poly_wr_en,
  input  pos_t      poly_wr_addr,
  input  coeff_t    poly_wr_data,

  // position load, LAC_LANES positions per word
  input  logic      pos_wr_en,
  input  pass_t     pos_wr_addr,
  input  pos_word_t pos_wr_data,

  // result readback
  input  logic      res_rd_en,
  input  pos_t      res_rd_addr,
  output coeff_t    res_rd_data,
  output logic      res_rd_valid
);

  logic pass_done;

  term_if term_bus ();
  acc_if  acc_bus ();

  operand_fetch u_fetch (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .busy         (busy),
    .done         (done),
    .poly_wr_en   (poly_wr_en),
    .poly_wr_addr (poly_wr_addr),
    .poly_wr_data (poly_wr_data),
    .pos_wr_en    (pos_wr_en),
    .pos_wr_addr  (pos_wr_addr),
    .pos_wr_data  (pos_wr_data),
    .pass_done    (pass_done),
    .term         (term_bus.src)
  );

  term_accumulate u_accum (
    .clk   (clk),
    .rst_n (rst_n),
    .term  (term_bus.dst),
    .acc   (acc_bus.src)
  );

  result_store u_store (
    .clk          (clk),
    .rst_n        (rst_n),
    .acc          (acc_bus.dst),
    .pass_done    (pass_done),
    .res_rd_en    (res_rd_en),
    .res_rd_addr  (res_rd_addr),
    .res_rd_data  (res_rd_data),
    .res_rd_valid (res_rd_valid)
  );

endmodule

/* include/sparse_mul_tb_check.svh */
/*
  reference model and typed compare tasks, included inside sparse_mul_tb
  expects dense_a, pos_list, errors and checks to be declared before the include
*/

`ifndef SPARSE_MUL_TB_CHECK_SVH
`define SPARSE_MUL_TB_CHECK_SVH

// ------------------------------
// reference model
// ------------------------------

// c[k] = sum over j of +-a[(k - p_j) mod N], all mod Q
// + for a first half position with k >= p_j, or a second half one with k < p_j
function automatic coeff_t model_coeff(input int k);
  int total;
  int pj;
  int idx;
  bit plus;
  total = 0;
  for (int j = 0; j < `LAC_H; j++)
  begin
    pj  = int'(pos_list[j]);
    idx = (k - pj + `LAC_N) % `LAC_N;
    if (j < `LAC_H / 2)
      plus = (k >= pj);
    else
      plus = (k < pj);
    if (plus)
      total = total + int'(dense_a[idx]);
    else
      total = total + `LAC_Q - int'(dense_a[idx]);
  end
  return coeff_t'(total % `LAC_Q);
endfunction

// ------------------------------
// compare tasks
// ------------------------------
task automatic check_coeff(input string name, input coeff_t got, input coeff_t exp);
  checks++;
  if (got !== exp)
  begin
    errors++;
    $display("error at %0d ns: %s expected %0d, got %0d", $time, name, exp, got);
  end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  checks++;
  if (got !== exp)
  begin
    errors++;
    $display("error at %0d ns: %s expected %b, got %b", $time, name, exp, got);
  end
endtask

`endif

/* dv/sparse_mul_tb.sv */
/*
  testbench for sparse_mul_top with three runs, two random and one directed
  inputs change 1 ns after the rising edge, outputs are sampled on the falling edge
*/

`timescale 1ns/1ps

`include "lac_defines.svh"

module sparse_mul_tb
  import lac_pkg::*;
();

  localparam int PASSES = `LAC_H / `LAC_LANES;
  // budget of four runs, three are executed and the spare covers loads and reset
  localparam int TIMEOUT_CYCLES = 4 * (PASSES * (`LAC_N + 16) + `LAC_N + 20);

  logic      clk;
  logic      rst_n;
  logic      start;
  logic      busy;
  logic      done;
  logic      poly_wr_en;
  pos_t      poly_wr_addr;
  coeff_t    poly_wr_data;
  logic      pos_wr_en;
  pass_t     pos_wr_addr;
  pos_word_t pos_wr_data;
  logic      res_rd_en;
  pos_t      res_rd_addr;
  coeff_t    res_rd_data;
  logic      res_rd_valid;

  // operands of the current run and the model result
  coeff_t dense_a [`LAC_N];
  pos_t   pos_list [`LAC_H];
  coeff_t expected [`LAC_N];

  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int unsigned lcg_state = 27;

`include "sparse_mul_tb_check.svh"

  sparse_mul_top uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .busy         (busy),
    .done         (done),
    .poly_wr_en   (poly_wr_en),
    .poly_wr_addr (poly_wr_addr),
    .poly_wr_data (poly_wr_data),
    .pos_wr_en    (pos_wr_en),
    .pos_wr_addr  (pos_wr_addr),
    .pos_wr_data  (pos_wr_data),
    .res_rd_en    (res_rd_en),
    .res_rd_addr  (res_rd_addr),
    .res_rd_data  (res_rd_data),
    .res_rd_valid (res_rd_valid)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 8;
  endfunction

  // ------------------------------
  // operand generation
  // ------------------------------

  // distinct positions, a collision steps to the next free index
  task automatic random_operands();
    bit used [`LAC_N];
    int cand;
    for (int i = 0; i < `LAC_N; i++)
    begin
      used[i]    = 1'b0;
      dense_a[i] = coeff_t'(next_rand() % `LAC_Q);
    end
    for (int j = 0; j < `LAC_H; j++)
    begin
      cand = next_rand() % `LAC_N;
      while (used[cand])
        cand = (cand + 1) % `LAC_N;
      used[cand]  = 1'b1;
      pos_list[j] = pos_t'(cand);
    end
  endtask

  // positions 0 and N-1 at both ends, coefficients 0 and Q-1 interleaved
  task automatic directed_operands();
    for (int i = 0; i < `LAC_N; i++)
    begin
      if (i % 4 == 0)
        dense_a[i] = '0;
      else if (i % 4 == 1)
        dense_a[i] = coeff_t'(`LAC_Q - 1);
      else
        dense_a[i] = coeff_t'(next_rand() % `LAC_Q);
    end
    for (int j = 0; j < `LAC_H; j++)
      pos_list[j] = pos_t'(4 * j + 1);
    pos_list[0]        = '0;
    pos_list[`LAC_H-1] = pos_t'(`LAC_N - 1);
  endtask

  // ------------------------------
  // DUT access
  // ------------------------------
  task automatic load_operands();
    for (int i = 0; i < `LAC_N; i++)
    begin
      @(posedge clk);
      #1;
      poly_wr_en   = 1'b1;
      poly_wr_addr = pos_t'(i);
      poly_wr_data = dense_a[i];
      pos_wr_en    = (i < PASSES);
      if (i < PASSES)
      begin
        pos_wr_addr = pass_t'(i);
        for (int l = 0; l < `LAC_LANES; l++)
          pos_wr_data[l] = pos_list[i * `LAC_LANES + l];
      end
    end
    @(posedge clk);
    #1;
    poly_wr_en = 1'b0;
    pos_wr_en  = 1'b0;
  endtask

  // busy must hold until the single done pulse, and drops with it
  task automatic start_and_wait();
    bit seen_done;
    seen_done = 1'b0;
    @(posedge clk);
    #1;
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    while (!seen_done)
    begin
      @(negedge clk);
      if (done)
      begin
        seen_done = 1'b1;
        check_flag("busy", busy, 1'b0);
      end
      else
        check_flag("busy", busy, 1'b1);
    end
    repeat (4)
    begin
      @(negedge clk);
      check_flag("done", done, 1'b0);
    end
  endtask

  // back to back reads, valid and data trail res_rd_en by one cycle
  task automatic read_and_compare();
    for (int i = 0; i <= `LAC_N; i++)
    begin
      @(posedge clk);
      #1;
      res_rd_en   = (i < `LAC_N);
      res_rd_addr = pos_t'(i);
      @(negedge clk);
      if (i == 0)
        check_flag("res_rd_valid", res_rd_valid, 1'b0);
      else
      begin
        check_flag("res_rd_valid", res_rd_valid, 1'b1);
        check_coeff($sformatf("res_rd_data[%0d]", i - 1), res_rd_data, expected[i-1]);
      end
    end
    @(negedge clk);
    check_flag("res_rd_valid", res_rd_valid, 1'b0);
  endtask

  task automatic run_and_check(input string label);
    $display("%0d ns: %s", $time, label);
    load_operands();
    for (int k = 0; k < `LAC_N; k++)
      expected[k] = model_coeff(k);
    start_and_wait();
    read_and_compare();
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial
  begin
    rst_n        = 1'b0;
    start        = 1'b0;
    poly_wr_en   = 1'b0;
    poly_wr_addr = '0;
    poly_wr_data = '0;
    pos_wr_en    = 1'b0;
    pos_wr_addr  = '0;
    pos_wr_data  = '0;
    res_rd_en    = 1'b0;
    res_rd_addr  = '0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_flag("busy", busy, 1'b0);
    check_flag("done", done, 1'b0);
    check_flag("res_rd_valid", res_rd_valid, 1'b0);

    random_operands();
    run_and_check("random run");
    // new operands, the first pass must not add onto the old result
    random_operands();
    run_and_check("second random run");
    directed_operands();
    run_and_check("directed wraparound run");

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

  initial
  begin
    while (cycles < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the test did not complete within %0d cycles", TIMEOUT_CYCLES);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

/* all.f */
+incdir+include
design/lac_pkg.sv
design/lac_stream_if.sv
design/operand_fetch.sv
design/term_accumulate.sv
design/result_store.sv
design/sparse_mul_top.sv
dv/sparse_mul_tb.sv

/* Bender.yml */
package:
  name: lac_sparse_mul

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/lac_pkg.sv
      - design/lac_stream_if.sv
      - design/operand_fetch.sv
      - design/term_accumulate.sv
      - design/result_store.sv
      - design/sparse_mul_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/sparse_mul_tb.sv
